//--- Bender.yml
package:
  name: addrgen

sources:
  - files:
      - rtl/addrgen_pkg.sv
      - rtl/addrgen_elem_cnt.sv
      - rtl/addrgen_burst_calc.sv
      - rtl/addrgen_cmd_fifo.sv
      - rtl/addrgen_ctrl.sv
      - rtl/addrgen_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/tb_addrgen_top.sv

//--- addrgen_top.f
+incdir+include
rtl/addrgen_pkg.sv
rtl/addrgen_elem_cnt.sv
rtl/addrgen_burst_calc.sv
rtl/addrgen_cmd_fifo.sv
rtl/addrgen_ctrl.sv
rtl/addrgen_top.sv
sim/tb_addrgen_top.sv

//--- rtl/addrgen_burst_calc.sv
// Current address register and burst length, size and consumed-element calculation
`timescale 1ns/1ps

module addrgen_burst_calc (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                load_i,
  input  logic                                step_i,
  input  logic [addrgen_pkg::ADDR_WIDTH-1:0]  addr_i,
  input  logic [addrgen_pkg::ADDR_WIDTH-1:0]  stride_i,
  input  logic [addrgen_pkg::VEW_WIDTH-1:0]   vew_i,
  input  logic                                unit_stride_i,
  input  logic [addrgen_pkg::LEN_WIDTH-1:0]   remaining_i,
  output logic [addrgen_pkg::ADDR_WIDTH-1:0]  addr_o,
  output logic [addrgen_pkg::BEATS_WIDTH-1:0] beats_o,
  output logic [addrgen_pkg::SIZE_WIDTH-1:0]  size_o,
  output logic [addrgen_pkg::LEN_WIDTH-1:0]   consumed_o,
  output logic                                misaligned_o
);

  // Request registers
  logic [addrgen_pkg::ADDR_WIDTH-1:0] addr_q, stride_q;
  logic [addrgen_pkg::VEW_WIDTH-1:0]  vew_q;
  logic                               unit_q;

  // Burst boundaries
  logic [addrgen_pkg::ADDR_WIDTH-1:0] aligned_start, bytes_left, last_byte;
  logic [addrgen_pkg::ADDR_WIDTH-1:0] max_end, page_end, burst_end;
  logic [addrgen_pkg::ADDR_WIDTH-1:0] word_cnt, burst_elems, next_start, vew_mask;

  // Start of the bus word holding the current address
  assign aligned_start = {addr_q[addrgen_pkg::ADDR_WIDTH-1:addrgen_pkg::BUS_SIZE_LOG],
                          {addrgen_pkg::BUS_SIZE_LOG{1'b0}}};

  // Candidate ends: data left, 256 beats, page end
  assign bytes_left = addrgen_pkg::ADDR_WIDTH'(remaining_i) << vew_q;
  assign last_byte  = addr_q + bytes_left - 1'b1;
  assign max_end    = aligned_start + addrgen_pkg::ADDR_WIDTH'(
                      addrgen_pkg::MAX_BURST_BEATS * addrgen_pkg::BUS_BYTES - 1);
  assign page_end   = {addr_q[addrgen_pkg::ADDR_WIDTH-1:addrgen_pkg::PAGE_BITS],
                       {addrgen_pkg::PAGE_BITS{1'b1}}};

  // Earliest of the three
  always_comb begin
    burst_end = last_byte;
    if (max_end < burst_end) begin
      burst_end = max_end;
    end
    if (page_end < burst_end) begin
      burst_end = page_end;
    end
  end

  // Bus words covered, minus one
  assign word_cnt    = (burst_end >> addrgen_pkg::BUS_SIZE_LOG) -
                       (aligned_start >> addrgen_pkg::BUS_SIZE_LOG);
  // Whole elements between the address and the burst end
  assign burst_elems = (burst_end - addr_q + 1'b1) >> vew_q;
  // Next burst starts at the following bus word
  assign next_start  = {burst_end[addrgen_pkg::ADDR_WIDTH-1:addrgen_pkg::BUS_SIZE_LOG] + 1'b1,
                        {addrgen_pkg::BUS_SIZE_LOG{1'b0}}};

  assign addr_o = addr_q;

  // Strided beats carry one element of the element width
  assign beats_o    = unit_q ? word_cnt[addrgen_pkg::BEATS_WIDTH-1:0] : '0;
  assign size_o     = unit_q ? addrgen_pkg::SIZE_WIDTH'(addrgen_pkg::BUS_SIZE_LOG)
                             : addrgen_pkg::SIZE_WIDTH'(vew_q);
  assign consumed_o = unit_q ? burst_elems[addrgen_pkg::LEN_WIDTH-1:0]
                             : addrgen_pkg::LEN_WIDTH'(1);

  // Low vew bits of the base must be zero
  assign vew_mask     = ~({addrgen_pkg::ADDR_WIDTH{1'b1}} << vew_q);
  assign misaligned_o = |(addr_q & vew_mask);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q   <= '0;
      stride_q <= '0;
      vew_q    <= '0;
      unit_q   <= 1'b0;
    end else if (load_i) begin
      addr_q   <= addr_i;
      stride_q <= stride_i;
      vew_q    <= vew_i;
      unit_q   <= unit_stride_i;
    end else if (step_i) begin
      addr_q <= unit_q ? next_start : addr_q + stride_q;
    end
  end

endmodule

//--- rtl/addrgen_cmd_fifo.sv
// Circular command queue of issued beats for the load/store units
`timescale 1ns/1ps

module addrgen_cmd_fifo (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                push_i,
  input  logic [addrgen_pkg::ADDR_WIDTH-1:0]  addr_i,
  input  logic [addrgen_pkg::BEATS_WIDTH-1:0] beats_i,
  input  logic [addrgen_pkg::SIZE_WIDTH-1:0]  size_i,
  input  logic                                is_load_i,
  input  logic                                pop_i,
  output logic [addrgen_pkg::ADDR_WIDTH-1:0]  cmd_addr_o,
  output logic [addrgen_pkg::BEATS_WIDTH-1:0] cmd_len_o,
  output logic [addrgen_pkg::SIZE_WIDTH-1:0]  cmd_size_o,
  output logic                                cmd_is_load_o,
  output logic                                full_o,
  output logic                                empty_o
);

  // Entry storage
  logic [addrgen_pkg::ADDR_WIDTH-1:0]  addr_mem    [addrgen_pkg::CMD_FIFO_DEPTH];
  logic [addrgen_pkg::BEATS_WIDTH-1:0] beats_mem   [addrgen_pkg::CMD_FIFO_DEPTH];
  logic [addrgen_pkg::SIZE_WIDTH-1:0]  size_mem    [addrgen_pkg::CMD_FIFO_DEPTH];
  logic                                is_load_mem [addrgen_pkg::CMD_FIFO_DEPTH];

  // Pointers wrap naturally, depth is a power of two
  logic [$clog2(addrgen_pkg::CMD_FIFO_DEPTH)-1:0] wr_ptr_q, rd_ptr_q;
  logic [$clog2(addrgen_pkg::CMD_FIFO_DEPTH):0]   count_q;

  assign full_o  = (count_q == addrgen_pkg::CMD_FIFO_DEPTH);
  assign empty_o = (count_q == '0);

  // Head entry
  assign cmd_addr_o    = addr_mem[rd_ptr_q];
  assign cmd_len_o     = beats_mem[rd_ptr_q];
  assign cmd_size_o    = size_mem[rd_ptr_q];
  assign cmd_is_load_o = is_load_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      addr_mem[wr_ptr_q]    <= addr_i;
      beats_mem[wr_ptr_q]   <= beats_i;
      size_mem[wr_ptr_q]    <= size_i;
      is_load_mem[wr_ptr_q] <= is_load_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keep the occupancy
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Consumer only pops a valid head
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o);

endmodule

//--- rtl/addrgen_ctrl.sv
// Request FSM with alignment check, beat issue, channel ordering and completion
`timescale 1ns/1ps

module addrgen_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic req_valid_i,
  input  logic req_is_load_i,
  input  logic misaligned_i,
  input  logic last_i,
  input  logic fifo_full_i,
  input  logic fifo_empty_i,
  input  logic fifo_head_is_load_i,
  input  logic ar_ready_i,
  input  logic aw_ready_i,
  output logic req_ready_o,
  output logic load_o,
  output logic step_o,
  output logic push_o,
  output logic is_load_o,
  output logic ar_valid_o,
  output logic aw_valid_o,
  output logic done_o,
  output logic error_o
);

  logic [addrgen_pkg::STATE_WIDTH-1:0] state_q, state_d;
  // Direction of the running request
  logic is_load_q;
  // Set while a raised valid waits for ready
  logic hold_q;
  logic order_ok;
  logic beat_valid;
  logic beat_hs;

  ////////////////////////////////////////////////////////////
  // Beat issue
  ////////////////////////////////////////////////////////////

  // A load waits behind a store at the queue head, and the reverse
  assign order_ok = fifo_empty_i || (fifo_head_is_load_i == is_load_q);

  // Queue space and ordering gate only the raising of valid and never a held one
  assign beat_valid = (state_q == addrgen_pkg::ST_ISSUE) &&
                      (hold_q || (!fifo_full_i && order_ok));

  assign ar_valid_o = beat_valid && is_load_q;
  assign aw_valid_o = beat_valid && !is_load_q;
  assign beat_hs    = (ar_valid_o && ar_ready_i) || (aw_valid_o && aw_ready_i);

  // Every handshake pushes a command and advances counter and address
  assign step_o    = beat_hs;
  assign push_o    = beat_hs;
  assign is_load_o = is_load_q;

  assign req_ready_o = (state_q == addrgen_pkg::ST_IDLE);
  assign load_o      = req_valid_i && req_ready_o;

  ////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    done_o  = 1'b0;
    error_o = 1'b0;
    case (state_q)
      addrgen_pkg::ST_IDLE: begin
        if (load_o) begin
          state_d = addrgen_pkg::ST_CHECK;
        end
      end
      addrgen_pkg::ST_CHECK: begin
        // Base not aligned to the element width is rejected right away
        if (misaligned_i) begin
          done_o  = 1'b1;
          error_o = 1'b1;
          state_d = addrgen_pkg::ST_IDLE;
        end else begin
          state_d = addrgen_pkg::ST_ISSUE;
        end
      end
      addrgen_pkg::ST_ISSUE: begin
        if (beat_hs && last_i) begin
          state_d = addrgen_pkg::ST_DONE;
        end
      end
      default: begin
        // Completion pulse after the last beat
        done_o  = 1'b1;
        state_d = addrgen_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= addrgen_pkg::ST_IDLE;
      is_load_q <= 1'b0;
      hold_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      hold_q  <= beat_valid && !beat_hs;
      if (load_o) begin
        is_load_q <= req_is_load_i;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  // Valid is held until ready even when the queue head changes
  a_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_o && !ar_ready_i |=> ar_valid_o);
  a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o && !aw_ready_i |=> aw_valid_o);

  // Queue can never overflow
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_o |-> !fifo_full_i);

endmodule

//--- rtl/addrgen_elem_cnt.sv
// Remaining-element counter with saturating step and last-beat flag
`timescale 1ns/1ps

module addrgen_elem_cnt (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              load_i,
  input  logic                              step_i,
  input  logic [addrgen_pkg::LEN_WIDTH-1:0] len_i,
  input  logic [addrgen_pkg::LEN_WIDTH-1:0] consumed_i,
  output logic [addrgen_pkg::LEN_WIDTH-1:0] remaining_o,
  output logic                              last_o
);

  logic [addrgen_pkg::LEN_WIDTH-1:0] remaining_q;

  // Current beat finishes the request
  assign last_o      = (consumed_i >= remaining_q);
  assign remaining_o = remaining_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      remaining_q <= '0;
    end else if (load_i) begin
      remaining_q <= len_i;
    end else if (step_i) begin
      // Saturate at zero when a burst covers more than is left
      if (last_o) begin
        remaining_q <= '0;
      end else begin
        remaining_q <= remaining_q - consumed_i;
      end
    end
  end

  // Beats only issue while elements are left
  a_no_step_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    step_i |-> remaining_q != '0);

endmodule

//--- rtl/addrgen_pkg.sv
// Shared widths, burst limits, page size, queue depth and controller state codes
package addrgen_pkg;

  ////////////////////////////////////////////////////////////
  // Request fields
  ////////////////////////////////////////////////////////////

  // Byte address
  localparam int unsigned ADDR_WIDTH = 32;
  // Element count of one request
  localparam int unsigned LEN_WIDTH  = 16;
  // Element width code, log2 of the element bytes (0 to 3)
  localparam int unsigned VEW_WIDTH  = 2;

  ////////////////////////////////////////////////////////////
  // AXI address channel
  ////////////////////////////////////////////////////////////

  // Data bus is 64 bits wide
  localparam int unsigned BUS_BYTES       = 8;
  localparam int unsigned BUS_SIZE_LOG    = 3;
  // AxSIZE and AxLEN field widths
  localparam int unsigned SIZE_WIDTH      = 3;
  localparam int unsigned BEATS_WIDTH     = 8;
  // INCR bursts stop at 256 beats and at 4 KiB pages
  localparam int unsigned MAX_BURST_BEATS = 256;
  localparam int unsigned PAGE_BITS       = 12;

  // Beats buffered for the load/store units
  localparam int unsigned CMD_FIFO_DEPTH = 4;

  // Controller states
  localparam int unsigned STATE_WIDTH = 2;
  localparam logic [STATE_WIDTH-1:0] ST_IDLE  = 2'd0;
  localparam logic [STATE_WIDTH-1:0] ST_CHECK = 2'd1;
  localparam logic [STATE_WIDTH-1:0] ST_ISSUE = 2'd2;
  localparam logic [STATE_WIDTH-1:0] ST_DONE  = 2'd3;

endpackage

//--- rtl/addrgen_top.sv
// Address generator top level wiring the controller, counter, burst calculator and queue
`timescale 1ns/1ps

module addrgen_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Vector memory request
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  logic [addrgen_pkg::ADDR_WIDTH-1:0]  req_addr_i,
  input  logic [addrgen_pkg::LEN_WIDTH-1:0]   req_len_i,
  input  logic [addrgen_pkg::ADDR_WIDTH-1:0]  req_stride_i,
  input  logic [addrgen_pkg::VEW_WIDTH-1:0]   req_vew_i,
  input  logic                                req_is_load_i,
  input  logic                                req_unit_stride_i,
  // AR channel
  output logic                                ar_valid_o,
  input  logic                                ar_ready_i,
  output logic [addrgen_pkg::ADDR_WIDTH-1:0]  ar_addr_o,
  output logic [addrgen_pkg::BEATS_WIDTH-1:0] ar_len_o,
  output logic [addrgen_pkg::SIZE_WIDTH-1:0]  ar_size_o,
  // AW channel
  output logic                                aw_valid_o,
  input  logic                                aw_ready_i,
  output logic [addrgen_pkg::ADDR_WIDTH-1:0]  aw_addr_o,
  output logic [addrgen_pkg::BEATS_WIDTH-1:0] aw_len_o,
  output logic [addrgen_pkg::SIZE_WIDTH-1:0]  aw_size_o,
  // Command queue towards the load/store units
  output logic                                cmd_valid_o,
  input  logic                                cmd_ready_i,
  output logic [addrgen_pkg::ADDR_WIDTH-1:0]  cmd_addr_o,
  output logic [addrgen_pkg::BEATS_WIDTH-1:0] cmd_len_o,
  output logic [addrgen_pkg::SIZE_WIDTH-1:0]  cmd_size_o,
  output logic                                cmd_is_load_o,
  // Completion
  output logic                                done_o,
  output logic                                error_o
);

  // Strobes from the controller
  logic load, step, push, is_load;
  // Status back to the controller
  logic misaligned, last;
  logic fifo_full, fifo_empty, fifo_pop;
  // Current beat
  logic [addrgen_pkg::ADDR_WIDTH-1:0]  beat_addr;
  logic [addrgen_pkg::BEATS_WIDTH-1:0] beat_len;
  logic [addrgen_pkg::SIZE_WIDTH-1:0]  beat_size;
  logic [addrgen_pkg::LEN_WIDTH-1:0]   remaining, consumed;

  // Same beat fields on both address channels, valid picks the channel
  assign ar_addr_o = beat_addr;
  assign ar_len_o  = beat_len;
  assign ar_size_o = beat_size;
  assign aw_addr_o = beat_addr;
  assign aw_len_o  = beat_len;
  assign aw_size_o = beat_size;

  assign cmd_valid_o = ~fifo_empty;
  assign fifo_pop    = cmd_valid_o & cmd_ready_i;

  addrgen_ctrl i_ctrl (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .req_valid_i        (req_valid_i),
    .req_is_load_i      (req_is_load_i),
    .misaligned_i       (misaligned),
    .last_i             (last),
    .fifo_full_i        (fifo_full),
    .fifo_empty_i       (fifo_empty),
    .fifo_head_is_load_i(cmd_is_load_o),
    .ar_ready_i         (ar_ready_i),
    .aw_ready_i         (aw_ready_i),
    .req_ready_o        (req_ready_o),
    .load_o             (load),
    .step_o             (step),
    .push_o             (push),
    .is_load_o          (is_load),
    .ar_valid_o         (ar_valid_o),
    .aw_valid_o         (aw_valid_o),
    .done_o             (done_o),
    .error_o            (error_o)
  );

  addrgen_elem_cnt i_elem_cnt (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .load_i     (load),
    .step_i     (step),
    .len_i      (req_len_i),
    .consumed_i (consumed),
    .remaining_o(remaining),
    .last_o     (last)
  );

  addrgen_burst_calc i_burst_calc (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .load_i       (load),
    .step_i       (step),
    .addr_i       (req_addr_i),
    .stride_i     (req_stride_i),
    .vew_i        (req_vew_i),
    .unit_stride_i(req_unit_stride_i),
    .remaining_i  (remaining),
    .addr_o       (beat_addr),
    .beats_o      (beat_len),
    .size_o       (beat_size),
    .consumed_o   (consumed),
    .misaligned_o (misaligned)
  );

  addrgen_cmd_fifo i_cmd_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (push),
    .addr_i       (beat_addr),
    .beats_i      (beat_len),
    .size_i       (beat_size),
    .is_load_i    (is_load),
    .pop_i        (fifo_pop),
    .cmd_addr_o   (cmd_addr_o),
    .cmd_len_o    (cmd_len_o),
    .cmd_size_o   (cmd_size_o),
    .cmd_is_load_o(cmd_is_load_o),
    .full_o       (fifo_full),
    .empty_o      (fifo_empty)
  );

endmodule

//--- include/tb_addrgen_model.svh
// Reference model tasks that expand one vector request into its expected beat list
`ifndef TB_ADDRGEN_MODEL_SVH
`define TB_ADDRGEN_MODEL_SVH

// Beat word as {is_load, size, len, addr}
function automatic logic [BEAT_W-1:0] pack_beat(
  input logic                                is_load,
  input logic [addrgen_pkg::SIZE_WIDTH-1:0]  size,
  input logic [addrgen_pkg::BEATS_WIDTH-1:0] len,
  input logic [addrgen_pkg::ADDR_WIDTH-1:0]  addr
);
  return {is_load, size, len, addr};
endfunction

// Same beat expected on the address channel and later on the command port
task automatic push_expected(input logic [BEAT_W-1:0] beat);
  exp_beat_q.push_back(beat);
  exp_cmd_q.push_back(beat);
endtask

// INCR bursts of bus words, cut at data end, 256 beats or page end
task automatic expand_unit(
  input logic [addrgen_pkg::ADDR_WIDTH-1:0] base,
  input logic [addrgen_pkg::LEN_WIDTH-1:0]  len,
  input logic [addrgen_pkg::VEW_WIDTH-1:0]  vew,
  input logic                               is_load
);
  logic [31:0] addr;
  logic [31:0] left;
  logic [31:0] start;
  logic [31:0] data_end;
  logic [31:0] cap_end;
  logic [31:0] page_end;
  logic [31:0] burst_end;
  logic [31:0] elems;
  addr = base;
  left = 32'(len);
  while (left != 0) begin
    start     = addr & ~32'(addrgen_pkg::BUS_BYTES - 1);
    data_end  = addr + (left << vew) - 1;
    cap_end   = start + 32'(addrgen_pkg::MAX_BURST_BEATS * addrgen_pkg::BUS_BYTES) - 1;
    page_end  = addr | ((32'd1 << addrgen_pkg::PAGE_BITS) - 1);
    burst_end = data_end;
    if (cap_end < burst_end) burst_end = cap_end;
    if (page_end < burst_end) burst_end = page_end;
    push_expected(pack_beat(is_load, 3'(addrgen_pkg::BUS_SIZE_LOG),
                            8'((burst_end - start) / addrgen_pkg::BUS_BYTES), addr));
    // Elements fully inside this burst
    elems = (burst_end - addr + 1) >> vew;
    left  = (elems >= left) ? 32'd0 : left - elems;
    addr  = (burst_end | 32'(addrgen_pkg::BUS_BYTES - 1)) + 1;
  end
endtask

// One single-beat transfer per element
task automatic expand_strided(
  input logic [addrgen_pkg::ADDR_WIDTH-1:0] base,
  input logic [addrgen_pkg::LEN_WIDTH-1:0]  len,
  input logic [addrgen_pkg::ADDR_WIDTH-1:0] stride,
  input logic [addrgen_pkg::VEW_WIDTH-1:0]  vew,
  input logic                               is_load
);
  logic [31:0] addr;
  addr = base;
  for (int i = 0; i < int'(len); i++) begin
    push_expected(pack_beat(is_load, 3'(vew), 8'd0, addr));
    addr = addr + stride;
  end
endtask

// Misaligned base gives no beats at all
task automatic expand_request(
  input  logic [addrgen_pkg::ADDR_WIDTH-1:0] base,
  input  logic [addrgen_pkg::LEN_WIDTH-1:0]  len,
  input  logic [addrgen_pkg::ADDR_WIDTH-1:0] stride,
  input  logic [addrgen_pkg::VEW_WIDTH-1:0]  vew,
  input  logic                               is_load,
  input  logic                               unit,
  output logic                               rejected
);
  rejected = (base & ((32'd1 << vew) - 1)) != 0;
  if (!rejected && unit) expand_unit(base, len, vew, is_load);
  else if (!rejected) expand_strided(base, len, stride, vew, is_load);
endtask

`endif

//--- sim/tb_addrgen_top.sv
// Testbench for the address generator with random requests, back-pressure and scoreboard
`timescale 1ns/1ps

module tb_addrgen_top;

  localparam int unsigned N_REQ         = 48;
  localparam int unsigned READY_TIMEOUT = 200;
  localparam int unsigned DONE_TIMEOUT  = 20000;
  localparam int unsigned DRAIN_TIMEOUT = 2000;
  localparam int unsigned BEAT_W = 1 + addrgen_pkg::SIZE_WIDTH + addrgen_pkg::BEATS_WIDTH +
                                   addrgen_pkg::ADDR_WIDTH;

  logic                                clk_i, rst_ni;
  logic                                req_valid_i, req_ready_o;
  logic [addrgen_pkg::ADDR_WIDTH-1:0]  req_addr_i, req_stride_i;
  logic [addrgen_pkg::LEN_WIDTH-1:0]   req_len_i;
  logic [addrgen_pkg::VEW_WIDTH-1:0]   req_vew_i;
  logic                                req_is_load_i, req_unit_stride_i;
  logic                                ar_valid_o, ar_ready_i, aw_valid_o, aw_ready_i;
  logic [addrgen_pkg::ADDR_WIDTH-1:0]  ar_addr_o, aw_addr_o, cmd_addr_o;
  logic [addrgen_pkg::BEATS_WIDTH-1:0] ar_len_o, aw_len_o, cmd_len_o;
  logic [addrgen_pkg::SIZE_WIDTH-1:0]  ar_size_o, aw_size_o, cmd_size_o;
  logic                                cmd_valid_o, cmd_ready_i, cmd_is_load_o;
  logic                                done_o, error_o;

  integer seed;
  // One queue of expected beats per consumer
  logic [BEAT_W-1:0] exp_beat_q[$];
  logic [BEAT_W-1:0] exp_cmd_q[$];
  // Request list built before reset
  logic [addrgen_pkg::ADDR_WIDTH-1:0] rq_addr [N_REQ];
  logic [addrgen_pkg::ADDR_WIDTH-1:0] rq_stride [N_REQ];
  logic [addrgen_pkg::LEN_WIDTH-1:0]  rq_len [N_REQ];
  logic [addrgen_pkg::VEW_WIDTH-1:0]  rq_vew [N_REQ];
  logic                               rq_load [N_REQ];
  logic                               rq_unit [N_REQ];
  // Monitor state
  int unsigned       done_cnt, done_exp;
  logic              done_q, ar_pend, aw_pend;
  logic [BEAT_W-1:0] ar_held, aw_held;

  `include "tb_addrgen_model.svh"

  addrgen_top addrgen_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////////////////////////

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
                          input string what);
    if (actual !== expected) begin
      stop_on_error($sformatf("Mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h",
                              $time, what, actual, expected));
    end
  endtask

  // Whole beat of any size stays in one 4 KiB page
  task automatic check_page(input logic [BEAT_W-1:0] beat);
    logic [31:0] first;
    logic [31:0] last;
    first = beat[31:0] & ~((32'd1 << beat[42:40]) - 1);
    last  = first + ((32'(beat[39:32]) + 1) << beat[42:40]) - 1;
    check_eq(first >> addrgen_pkg::PAGE_BITS, last >> addrgen_pkg::PAGE_BITS,
             "beat crosses a 4 KiB page");
  endtask

  task automatic compare_beat(input logic [BEAT_W-1:0] beat, input string chan);
    check_page(beat);
    if (exp_beat_q.size() == 0) begin
      stop_on_error({"Unexpected ", chan, " beat with no beat pending in the model"});
    end else begin
      check_eq(beat, exp_beat_q.pop_front(), {chan, " beat {is_load,size,len,addr}"});
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Small counts near page edges with a few long ones and about 1 in 8 misaligned
  task automatic generate_requests();
    logic        misal;
    logic [31:0] offs;
    for (int i = 0; i < N_REQ; i++) begin
      misal      = ($random(seed) & 7) == 0;
      rq_vew[i]  = misal ? 2'(1 + $unsigned($random(seed)) % 3) : 2'($random(seed) & 3);
      rq_unit[i] = 1'($random(seed) & 1);
      rq_load[i] = 1'($random(seed) & 1);
      if (($random(seed) & 7) == 0) rq_len[i] = 16'(1 + $unsigned($random(seed)) % 600);
      else rq_len[i] = 16'(1 + $unsigned($random(seed)) % 24);
      offs = $unsigned($random(seed)) % 128;
      if ($random(seed) & 1) offs = 4096 - 128 + offs;
      rq_addr[i] = (1 + $unsigned($random(seed)) % 64) * 4096 + offs;
      rq_addr[i] = rq_addr[i] & ~((32'd1 << rq_vew[i]) - 1);
      if (misal) rq_addr[i] = rq_addr[i] | 32'd1;
      rq_stride[i] = 32'(($random(seed) & 31) - 8) << rq_vew[i];
    end
  endtask

  task automatic run_request(input int idx);
    int unsigned cnt;
    logic        rejected;
    cnt = 0;
    @(posedge clk_i);
    while (!req_ready_o) begin
      cnt++;
      if (cnt > READY_TIMEOUT) stop_on_error("Timeout: req_ready_o did not rise for a request");
      @(posedge clk_i);
    end
    check_eq(done_cnt, done_exp, "done_o pulse count before a new request");
    req_valid_i       <= 1'b1;
    req_addr_i        <= rq_addr[idx];
    req_len_i         <= rq_len[idx];
    req_stride_i      <= rq_stride[idx];
    req_vew_i         <= rq_vew[idx];
    req_is_load_i     <= rq_load[idx];
    req_unit_stride_i <= rq_unit[idx];
    @(posedge clk_i);
    check_eq(req_ready_o, 1'b1, "req_ready_o at request handshake");
    req_valid_i <= 1'b0;
    expand_request(rq_addr[idx], rq_len[idx], rq_stride[idx], rq_vew[idx],
                   rq_load[idx], rq_unit[idx], rejected);
    // Check cycle
    @(posedge clk_i);
    if (rejected) begin
      check_eq({done_o, error_o}, 2'b11, "done_o and error_o for a misaligned base");
      @(posedge clk_i);
      check_eq(req_ready_o, 1'b1, "req_ready_o after a rejected request");
    end else begin
      check_eq(done_o, 1'b0, "done_o in the check cycle of an aligned request");
      cnt = 0;
      do begin
        @(posedge clk_i);
        cnt++;
        if (cnt > DONE_TIMEOUT) stop_on_error("Timeout: done_o never pulsed for a request");
      end while (!done_o);
      check_eq(error_o, 1'b0, "error_o for an aligned request");
      check_eq(exp_beat_q.size(), 0, "model beats still missing at done_o");
    end
    done_exp++;
  endtask

  // Random back-pressure on every ready input
  always @(posedge clk_i) begin
    if (rst_ni) begin
      ar_ready_i  <= 1'($random(seed) & 1);
      aw_ready_i  <= 1'($random(seed) & 1);
      cmd_ready_i <= ($random(seed) & 3) != 0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (ar_valid_o && aw_valid_o) stop_on_error("AR and AW valid were high together");
      if (ar_pend) begin
        check_eq(ar_valid_o, 1'b1, "ar_valid_o dropped before ar_ready_i");
        check_eq(pack_beat(1'b1, ar_size_o, ar_len_o, ar_addr_o), ar_held, "AR held fields");
      end
      if (aw_pend) begin
        check_eq(aw_valid_o, 1'b1, "aw_valid_o dropped before aw_ready_i");
        check_eq(pack_beat(1'b0, aw_size_o, aw_len_o, aw_addr_o), aw_held, "AW held fields");
      end
      // Ordering against the command queue head
      if (ar_valid_o && cmd_valid_o && !cmd_is_load_o) begin
        stop_on_error("AR beat raised while the command head is a store");
      end
      if (aw_valid_o && cmd_valid_o && cmd_is_load_o) begin
        stop_on_error("AW beat raised while the command head is a load");
      end
      if (ar_valid_o && ar_ready_i) begin
        compare_beat(pack_beat(1'b1, ar_size_o, ar_len_o, ar_addr_o), "AR");
      end
      if (aw_valid_o && aw_ready_i) begin
        compare_beat(pack_beat(1'b0, aw_size_o, aw_len_o, aw_addr_o), "AW");
      end
      if (cmd_valid_o && cmd_ready_i) begin
        if (exp_cmd_q.size() == 0) begin
          stop_on_error("Command entry popped with none expected");
        end else begin
          check_eq(pack_beat(cmd_is_load_o, cmd_size_o, cmd_len_o, cmd_addr_o),
                   exp_cmd_q.pop_front(), "command entry {is_load,size,len,addr}");
        end
      end
      if (done_o && done_q) stop_on_error("done_o stayed high for more than one cycle");
      if (done_o) done_cnt++;
      done_q  = done_o;
      ar_pend = ar_valid_o && !ar_ready_i;
      aw_pend = aw_valid_o && !aw_ready_i;
      ar_held = pack_beat(1'b1, ar_size_o, ar_len_o, ar_addr_o);
      aw_held = pack_beat(1'b0, aw_size_o, aw_len_o, aw_addr_o);
    end
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int unsigned cnt;
    seed              = 32'hcc8a_5f5e;
    rst_ni            = 1'b0;
    req_valid_i       = 1'b0;
    req_addr_i        = '0;
    req_len_i         = '0;
    req_stride_i      = '0;
    req_vew_i         = '0;
    req_is_load_i     = 1'b0;
    req_unit_stride_i = 1'b0;
    ar_ready_i        = 1'b0;
    aw_ready_i        = 1'b0;
    cmd_ready_i       = 1'b0;
    done_cnt          = 0;
    done_exp          = 0;
    done_q            = 1'b0;
    ar_pend           = 1'b0;
    aw_pend           = 1'b0;
    generate_requests();
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    check_eq(req_ready_o, 1'b1, "req_ready_o after reset");
    check_eq({ar_valid_o, aw_valid_o, cmd_valid_o, done_o, error_o}, 5'b0,
             "valid, done and error outputs after reset");
    for (int i = 0; i < N_REQ; i++) begin
      run_request(i);
    end
    // Let the load/store side drain the queue
    cnt = 0;
    while (exp_cmd_q.size() != 0) begin
      cnt++;
      if (cnt > DRAIN_TIMEOUT) stop_on_error("Timeout: command queue did not drain");
      @(posedge clk_i);
    end
    @(posedge clk_i);
    check_eq(done_cnt, N_REQ, "done_o pulses over the whole run");
    check_eq(cmd_valid_o, 1'b0, "cmd_valid_o after draining");
    $display("No errors");
    $finish;
  end

endmodule
